// ==== verilog/msg_ram_pkg.sv ====
// shared widths and types for the banked variable-to-check message store
package msg_ram_pkg;

	// code shape, one bank per (variable, check) pair
	localparam int VARIABLE_DEGREE = 3; // variable-side rows
	localparam int CHECK_DEGREE    = 5; // check-side columns
	localparam int NUM_BANKS       = VARIABLE_DEGREE * CHECK_DEGREE;

	// storage geometry
	localparam int DEF_RAM_SIZE = 31; // rows in use per bank
	localparam int ADDR_WIDTH   = 5;  // holds any row below the depth

	localparam int TAG_WIDTH   = 8;
	localparam int READ_STAGES = 4; // addr capture, add, wrap, bank read

	typedef logic [7:0]            msg_t;  // one message
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [TAG_WIDTH-1:0]  tag_t;

	// whole row of messages, index is the bank number in variable-major order
	typedef msg_t msg_bus_t [NUM_BANKS];

	// one address per bank, used for offsets and for the rotated addresses
	typedef addr_t offset_vec_t [NUM_BANKS];

endpackage

// ==== verilog/pipe_ctrl.sv ====
`timescale 1ns/1ps

// valid and tag train for the read pipeline
// every stage register in the read path moves on advance, so a stalled
// output freezes the whole pipe and nothing is dropped or duplicated
module pipe_ctrl import msg_ram_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic in_valid, // read request from upstream
	input  tag_t in_tag,
	input  logic out_ready, // downstream takes the output this cycle
	output logic advance, // shift enable for all read stages
	output logic out_valid,
	output tag_t out_tag,
	output logic busy // some read is in flight
);

localparam int LAST = READ_STAGES - 1;

logic [READ_STAGES-1:0] valid_q; // bit 0 is the first stage
tag_t tag_q [READ_STAGES];

// move when the last stage is empty or being consumed
assign advance = out_ready | ~valid_q[LAST];

always_ff @(posedge clk, posedge reset) begin
	if (1'b1 == reset) begin
		valid_q <= '0;
	end else if (advance) begin
		valid_q <= {valid_q[LAST-1:0], in_valid}; // shift toward the output
	end
end

// tags ride alongside the valid flags
always_ff @(posedge clk) begin
	if (advance) begin
		tag_q[0] <= in_tag;
		for (int i = 1; i < READ_STAGES; i++) begin
			tag_q[i] <= tag_q[i-1];
		end
	end
end

assign out_valid = valid_q[LAST];
assign out_tag   = tag_q[LAST];
assign busy      = |valid_q; // low only when every stage is a bubble

// a stalled output item stays put until it is taken
a_out_hold: assert property (
	@(posedge clk) disable iff (reset)
	out_valid && !out_ready |=> out_valid && $stable(out_tag)
) else $error("pipe_ctrl: output changed while stalled");

endmodule

// ==== verilog/addr_rotate.sv ====
`timescale 1ns/1ps

// per-bank read address generation
// stage 1 captures the base row, stage 2 adds each bank's offset,
// stage 3 folds the sum back into 0..RAM_SIZE-1
module addr_rotate import msg_ram_pkg::*; #(
	parameter int RAM_SIZE = DEF_RAM_SIZE
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        advance, // pipe moves on this
	input  addr_t       read_address, // base row, below RAM_SIZE
	input  offset_vec_t bank_offsets, // held stable while reads are in flight
	output offset_vec_t bank_addr // wrapped row per bank, stage 3
);

typedef logic [ADDR_WIDTH:0] sum_t; // one carry bit above the address

addr_t base_q; // stage 1
sum_t  sum_q [NUM_BANKS]; // stage 2

always_ff @(posedge clk, posedge reset) begin
	if (1'b1 == reset) begin
		base_q <= '0;
	end else if (advance) begin
		base_q <= read_address;
	end
end

// offsets are below RAM_SIZE, so one subtract is enough to wrap
always_ff @(posedge clk, posedge reset) begin
	if (1'b1 == reset) begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			sum_q[b]     <= '0;
			bank_addr[b] <= '0;
		end
	end else if (advance) begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			sum_q[b] <= {1'b0, base_q} + {1'b0, bank_offsets[b]}; // up to 2*RAM_SIZE-2
			if (sum_q[b] >= RAM_SIZE) begin
				bank_addr[b] <= addr_t'(sum_q[b] - RAM_SIZE); // wrapped past the end
			end else begin
				bank_addr[b] <= addr_t'(sum_q[b]);
			end
		end
	end
end

// the base row taken in must already be inside the bank
a_base_range: assert property (
	@(posedge clk) disable iff (reset)
	advance && !$isunknown(read_address) |-> read_address < RAM_SIZE
) else $error("addr_rotate: base row %0d out of range", read_address);

// after add and wrap every bank lands inside its memory, needs offsets below RAM_SIZE too
for (genvar g = 0; g < NUM_BANKS; g++) begin : g_wrap_chk
	a_wrap_range: assert property (
		@(posedge clk) disable iff (reset)
		advance |=> bank_addr[g] < RAM_SIZE
	) else $error("addr_rotate: bank %0d address %0d not wrapped", g, bank_addr[g]);
end

endmodule

// ==== verilog/sdp_bank.sv ====
`timescale 1ns/1ps

// one simple dual-port block ram, write port and registered read port
module sdp_bank import msg_ram_pkg::*; #(
	parameter int RAM_SIZE = DEF_RAM_SIZE
) (
	input  logic  clk,
	input  logic  write_enable,
	input  addr_t write_address,
	input  msg_t  write_data,
	input  logic  read_enable, // held low freezes the output register
	input  addr_t read_address,
	output msg_t  read_data // stage 4 of the read pipe
);

msg_t mem [RAM_SIZE];

always_ff @(posedge clk) begin
	if (write_enable) begin
		mem[write_address] <= write_data;
	end
end

// same-row write in the same cycle returns the old word
always_ff @(posedge clk) begin
	if (read_enable) begin
		read_data <= mem[read_address];
	end
end

a_wr_range: assert property (
	@(posedge clk) write_enable |-> write_address < RAM_SIZE
) else $error("sdp_bank: write row %0d beyond depth %0d", write_address, RAM_SIZE);

endmodule

// ==== verilog/bank_array.sv ====
`timescale 1ns/1ps

// write capture with the check-major to variable-major transpose,
// and the array of message banks read in parallel
module bank_array import msg_ram_pkg::*; #(
	parameter int RAM_SIZE = DEF_RAM_SIZE
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        advance, // read enable for every bank
	input  offset_vec_t bank_addr, // wrapped read row per bank
	input  logic        write_valid,
	input  addr_t       write_address,
	input  msg_bus_t    write_data, // check-major, element c*VARIABLE_DEGREE+v
	output msg_bus_t    read_data, // bank order
	output logic        write_busy // a captured write has not reached the banks yet
);

msg_bus_t wr_bank_data; // write bus reordered into banks
msg_bus_t wr_data_q;
addr_t    wr_addr_q;
logic     wr_pend_q; // bank write enable, one cycle after capture

// input element c*VD+v belongs to bank v*CD+c
always_comb begin
	for (int v = 0; v < VARIABLE_DEGREE; v++) begin
		for (int c = 0; c < CHECK_DEGREE; c++) begin
			wr_bank_data[v*CHECK_DEGREE + c] = write_data[c*VARIABLE_DEGREE + v];
		end
	end
end

always_ff @(posedge clk, posedge reset) begin
	if (1'b1 == reset) begin
		wr_pend_q <= 1'b0;
	end else begin
		wr_pend_q <= write_valid; // always ready, one write per cycle
	end
end

always_ff @(posedge clk) begin
	if (write_valid) begin
		wr_addr_q <= write_address;
		wr_data_q <= wr_bank_data;
	end
end

assign write_busy = wr_pend_q;

// all banks share the write row and the write strobe, no offsets on this side
for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
	sdp_bank #(
		.RAM_SIZE(RAM_SIZE)
	) u_bank (
		.clk          (clk),
		.write_enable (wr_pend_q),
		.write_address(wr_addr_q),
		.write_data   (wr_data_q[b]),
		.read_enable  (advance), // stalls hold the read register
		.read_address (bank_addr[b]),
		.read_data    (read_data[b])
	);
end

endmodule

// ==== verilog/msg_ram_top.sv ====
`timescale 1ns/1ps

// banked variable-to-check message store
// read latency is READ_STAGES advancing cycles, writes land one cycle after capture
module msg_ram_top import msg_ram_pkg::*; #(
	parameter int RAM_SIZE = DEF_RAM_SIZE
) (
	input  logic        clk,
	input  logic        reset,
	input  offset_vec_t bank_offsets, // per-bank row rotation, each below RAM_SIZE

	// read request side
	input  logic        read_valid,
	input  tag_t        read_tag,
	input  addr_t       read_address,
	output logic        read_ready_out,
	output logic        read_busy,

	// read result side
	input  logic        read_ready_in,
	output logic        read_valid_out,
	output tag_t        read_tag_out,
	output msg_bus_t    read_data_out, // variable-major bank order

	// write side, always ready
	input  logic        write_valid,
	input  addr_t       write_address,
	input  msg_bus_t    write_data, // check-major
	output logic        write_busy
);

logic        advance; // shared stage enable
offset_vec_t bank_addr; // rotated rows into the banks

// depth has to fit the address width
if (RAM_SIZE > (1 << ADDR_WIDTH) || RAM_SIZE < 1) begin : g_bad_size
	$error("msg_ram_top: RAM_SIZE %0d does not fit %0d address bits", RAM_SIZE, ADDR_WIDTH);
end

assign read_ready_out = advance; // a request is taken whenever the pipe moves

pipe_ctrl u_pipe (
	.clk      (clk),
	.reset    (reset),
	.in_valid (read_valid),
	.in_tag   (read_tag),
	.out_ready(read_ready_in),
	.advance  (advance),
	.out_valid(read_valid_out),
	.out_tag  (read_tag_out),
	.busy     (read_busy)
);

addr_rotate #(
	.RAM_SIZE(RAM_SIZE)
) u_rotate (
	.clk         (clk),
	.reset       (reset),
	.advance     (advance),
	.read_address(read_address),
	.bank_offsets(bank_offsets),
	.bank_addr   (bank_addr) // stage 3
);

bank_array #(
	.RAM_SIZE(RAM_SIZE)
) u_banks (
	.clk          (clk),
	.reset        (reset),
	.advance      (advance),
	.bank_addr    (bank_addr),
	.write_valid  (write_valid),
	.write_address(write_address),
	.write_data   (write_data),
	.read_data    (read_data_out), // stage 4, lines up with read_valid_out
	.write_busy   (write_busy)
);

endmodule

// ==== tb/tb_msg_ram.sv ====
`timescale 1ns/1ps

// testbench for the banked message store driven from the golden command file
module tb_msg_ram import msg_ram_pkg::*; ();

localparam time PERIOD      = 100;
localparam time DRIVE_DELAY = 10; // inputs change this long after the rising edge
localparam int  RESET_CYCLES = 4;
localparam logic [31:0] SEED = 32'hb5367c35;

logic        clk;
logic        reset;
offset_vec_t bank_offsets;
logic        read_valid;
tag_t        read_tag;
addr_t       read_address;
logic        read_ready_out;
logic        read_busy;
logic        read_ready_in;
logic        read_valid_out;
tag_t        read_tag_out;
msg_bus_t    read_data_out;
logic        write_valid;
addr_t       write_address;
msg_bus_t    write_data;
logic        write_busy;

int data_errors;
int tag_errors;
int flag_errors;
int other_errors;

// expected results in order of acceptance
tag_t                   exp_tag_q[$];
logic [8*NUM_BANKS-1:0] exp_data_q[$];
string                  exp_name_q[$];
int                     acc_q[$]; // advance count at each accepted read

int       adv_count; // advancing edges seen so far
int       cycles;
int       limit; // watchdog limit in cycles, zero until the golden file is counted
logic     stall_mode; // random back-pressure on read_ready_in
logic     stall_prev; // output was stalled at the previous sample
tag_t     held_tag;
msg_bus_t held_data;
logic     wv_prev;

msg_ram_top #(
	.RAM_SIZE(DEF_RAM_SIZE)
) UUT (
	.clk           (clk),
	.reset         (reset),
	.bank_offsets  (bank_offsets),
	.read_valid    (read_valid),
	.read_tag      (read_tag),
	.read_address  (read_address),
	.read_ready_out(read_ready_out),
	.read_busy     (read_busy),
	.read_ready_in (read_ready_in),
	.read_valid_out(read_valid_out),
	.read_tag_out  (read_tag_out),
	.read_data_out (read_data_out),
	.write_valid   (write_valid),
	.write_address (write_address),
	.write_data    (write_data),
	.write_busy    (write_busy)
);

initial begin
	clk = 1'b0;
	forever #(PERIOD/2) clk = ~clk;
end

task automatic compare_msg_bus(input string name, input msg_bus_t exp, input msg_bus_t act);
	for (int b = 0; b < NUM_BANKS; b++) begin
		if (act[b] !== exp[b]) begin
			data_errors++;
			$display("[FAIL] %s bank %0d: expected %h, actual %h", name, b, exp[b], act[b]);
		end
	end
endtask

task automatic compare_tag(input string name, input tag_t exp, input tag_t act);
	if (act !== exp) begin
		tag_errors++;
		$display("[FAIL] %s: expected tag %h, actual %h", name, exp, act);
	end
endtask

task automatic compare_flag(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		flag_errors++;
		$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
	end
endtask

function automatic logic [8*NUM_BANKS-1:0] pack_bus(input msg_bus_t bus);
	logic [8*NUM_BANKS-1:0] flat;
	for (int b = 0; b < NUM_BANKS; b++) begin
		flat[8*b +: 8] = bus[b];
	end
	return flat;
endfunction

function automatic msg_bus_t unpack_bus(input logic [8*NUM_BANKS-1:0] flat);
	msg_bus_t bus;
	for (int b = 0; b < NUM_BANKS; b++) begin
		bus[b] = flat[8*b +: 8];
	end
	return bus;
endfunction

// random back-pressure on the result side
initial begin
	read_ready_in = 1'b1;
	void'($urandom(SEED));
	forever begin
		@(posedge clk);
		#DRIVE_DELAY;
		read_ready_in = stall_mode ? (($urandom % 4) != 0) : 1'b1;
	end
end

// result side sampled mid-cycle where everything has settled
initial begin
	string name;
	int    lat;
	adv_count  = 0;
	stall_prev = 1'b0;
	wv_prev    = 1'b0;
	forever begin
		@(negedge clk);
		if (!reset) begin
			if (stall_prev) begin // held item must not move
				compare_flag("stalled read_valid_out", 1'b1, read_valid_out);
				compare_tag("stalled read_tag_out", held_tag, read_tag_out);
				compare_msg_bus("stalled read_data_out", held_data, read_data_out);
			end
			if (!read_ready_out && !(read_valid_out && !read_ready_in)) begin
				other_errors++;
				$display("read_ready_out is low although the output stage can move");
			end
			compare_flag("read_busy", acc_q.size() != 0, read_busy);
			compare_flag("write_busy", wv_prev, write_busy); // one cycle after the write
			if (read_valid_out && read_ready_in) begin
				if (exp_tag_q.size() == 0 || acc_q.size() == 0) begin
					other_errors++;
					$display("read result with tag %h appeared with no read outstanding",
						read_tag_out);
				end else begin
					name = exp_name_q.pop_front();
					compare_tag(name, exp_tag_q.pop_front(), read_tag_out);
					compare_msg_bus(name, unpack_bus(exp_data_q.pop_front()), read_data_out);
					lat = adv_count - acc_q.pop_front();
					if (lat != READ_STAGES) begin
						other_errors++;
						$display("%s came out after %0d advancing cycles, not %0d",
							name, lat, READ_STAGES);
					end
				end
			end
			if (read_valid && read_ready_out) acc_q.push_back(adv_count); // taken next edge
			if (read_ready_out) adv_count++;
			stall_prev = read_valid_out && !read_ready_in;
			held_tag   = read_tag_out;
			held_data  = read_data_out;
			wv_prev    = write_valid;
		end
	end
end

// watchdog
initial begin
	cycles = 0;
	while (limit == 0 || cycles < limit) begin
		@(posedge clk);
		cycles++;
	end
	$display("timeout after %0d cycles with %0d read results still missing",
		cycles, exp_tag_q.size());
	$display("Simulation finished: FAIL");
	$finish;
end

// wait until no read is in flight before offsets change
task automatic drain_reads();
	while (read_busy || exp_tag_q.size() != 0) begin
		@(posedge clk);
		#DRIVE_DELAY;
	end
endtask

initial begin
	int       fd;
	int       n;
	int       val;
	int       line_count;
	int       total;
	string    cmd;
	string    text;
	msg_bus_t bus;
	limit         = 0;
	data_errors   = 0;
	tag_errors    = 0;
	flag_errors   = 0;
	other_errors  = 0;
	stall_mode    = 1'b0;
	reset         = 1'b1;
	read_valid    = 1'b0;
	read_tag      = '0;
	read_address  = '0;
	write_valid   = 1'b0;
	write_address = '0;
	for (int b = 0; b < NUM_BANKS; b++) begin
		bank_offsets[b] = '0;
		write_data[b]   = '0;
	end

	// size the timeout from the length of the golden file
	line_count = 0;
	fd = $fopen("tb/msg_ram_golden.txt", "r");
	if (fd != 0) begin
		while (!$feof(fd)) begin
			if ($fgets(text, fd) != 0) line_count++;
		end
		$fclose(fd);
	end
	limit = 4 * (line_count + READ_STAGES) + 200;

	repeat (RESET_CYCLES) @(posedge clk);
	#DRIVE_DELAY;
	reset = 1'b0;
	@(negedge clk);
	compare_flag("reset read_valid_out", 1'b0, read_valid_out);
	compare_flag("reset read_busy", 1'b0, read_busy);
	compare_flag("reset write_busy", 1'b0, write_busy);
	compare_flag("reset read_ready_out", 1'b1, read_ready_out);
	@(posedge clk);
	#DRIVE_DELAY;

	fd = $fopen("tb/msg_ram_golden.txt", "r");
	if (fd == 0) begin
		other_errors++;
		$display("golden file tb/msg_ram_golden.txt could not be opened");
	end else begin
		while (!$feof(fd)) begin
			n = $fscanf(fd, "%s", cmd);
			if (n != 1) break;
			case (cmd)
				"#": void'($fgets(text, fd)); // comment line in the golden file
				"O": begin
					drain_reads();
					for (int b = 0; b < NUM_BANKS; b++) begin
						void'($fscanf(fd, "%d", val));
						bank_offsets[b] = addr_t'(val);
					end
				end
				"M": begin
					void'($fscanf(fd, "%d", val));
					stall_mode = (val != 0);
				end
				"W": begin
					void'($fscanf(fd, "%d", val));
					write_address = addr_t'(val);
					for (int e = 0; e < NUM_BANKS; e++) begin
						void'($fscanf(fd, "%h", val));
						write_data[e] = msg_t'(val);
					end
					write_valid = 1'b1; // port is always ready so the next edge takes it
					@(posedge clk);
					#DRIVE_DELAY;
					write_valid = 1'b0;
				end
				"R": begin
					void'($fscanf(fd, "%d", val));
					read_address = addr_t'(val);
					void'($fscanf(fd, "%h", val));
					read_tag = tag_t'(val);
					for (int b = 0; b < NUM_BANKS; b++) begin
						void'($fscanf(fd, "%h", val));
						bus[b] = msg_t'(val);
					end
					exp_name_q.push_back($sformatf("read tag %h row %0d", read_tag,
						read_address));
					exp_tag_q.push_back(read_tag);
					exp_data_q.push_back(pack_bus(bus));
					read_valid = 1'b1;
					do begin
						@(negedge clk);
					end while (!read_ready_out);
					@(posedge clk);
					#DRIVE_DELAY;
					read_valid = 1'b0;
				end
				"I": begin
					void'($fscanf(fd, "%d", val));
					repeat (val) begin
						@(posedge clk);
						#DRIVE_DELAY;
					end
				end
				default: begin
					other_errors++;
					$display("unknown command %s in the golden file", cmd);
				end
			endcase
		end
		$fclose(fd);
	end

	drain_reads();
	repeat (2) @(posedge clk);
	total = data_errors + tag_errors + flag_errors + other_errors;
	$display("errors: %0d total, data %0d, tag %0d, flag %0d, other %0d",
		total, data_errors, tag_errors, flag_errors, other_errors);
	if (total == 0) begin
		$display("Simulation finished: PASS");
	end else begin
		$display("Simulation finished: FAIL");
	end
	$finish;
end

endmodule

// ==== filelist.f ====
verilog/msg_ram_pkg.sv
verilog/pipe_ctrl.sv
verilog/addr_rotate.sv
verilog/sdp_bank.sv
verilog/bank_array.sv
verilog/msg_ram_top.sv
tb/tb_msg_ram.sv

// ==== tb/msg_ram_golden.txt ====
# O off0..off14 (decimal) | W row d0..d14 (hex, check-major) | I cycles | M stall(0/1)
# R row tag(hex) e0..e14 (hex, expected per bank in variable-major order)
# element e of row r holds 8*r+e
O 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
M 0
W 0 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e
W 1 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16
W 2 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e
W 3 18 19 1a 1b 1c 1d 1e 1f 20 21 22 23 24 25 26
W 4 20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e
W 5 28 29 2a 2b 2c 2d 2e 2f 30 31 32 33 34 35 36
W 6 30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e
W 7 38 39 3a 3b 3c 3d 3e 3f 40 41 42 43 44 45 46
W 8 40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e
W 9 48 49 4a 4b 4c 4d 4e 4f 50 51 52 53 54 55 56
W 10 50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e
W 11 58 59 5a 5b 5c 5d 5e 5f 60 61 62 63 64 65 66
W 12 60 61 62 63 64 65 66 67 68 69 6a 6b 6c 6d 6e
W 13 68 69 6a 6b 6c 6d 6e 6f 70 71 72 73 74 75 76
W 14 70 71 72 73 74 75 76 77 78 79 7a 7b 7c 7d 7e
W 15 78 79 7a 7b 7c 7d 7e 7f 80 81 82 83 84 85 86
W 16 80 81 82 83 84 85 86 87 88 89 8a 8b 8c 8d 8e
W 17 88 89 8a 8b 8c 8d 8e 8f 90 91 92 93 94 95 96
W 18 90 91 92 93 94 95 96 97 98 99 9a 9b 9c 9d 9e
W 19 98 99 9a 9b 9c 9d 9e 9f a0 a1 a2 a3 a4 a5 a6
W 20 a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab ac ad ae
W 21 a8 a9 aa ab ac ad ae af b0 b1 b2 b3 b4 b5 b6
W 22 b0 b1 b2 b3 b4 b5 b6 b7 b8 b9 ba bb bc bd be
W 23 b8 b9 ba bb bc bd be bf c0 c1 c2 c3 c4 c5 c6
W 24 c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 ca cb cc cd ce
W 25 c8 c9 ca cb cc cd ce cf d0 d1 d2 d3 d4 d5 d6
W 26 d0 d1 d2 d3 d4 d5 d6 d7 d8 d9 da db dc dd de
W 27 d8 d9 da db dc dd de df e0 e1 e2 e3 e4 e5 e6
W 28 e0 e1 e2 e3 e4 e5 e6 e7 e8 e9 ea eb ec ed ee
W 29 e8 e9 ea eb ec ed ee ef f0 f1 f2 f3 f4 f5 f6
W 30 f0 f1 f2 f3 f4 f5 f6 f7 f8 f9 fa fb fc fd fe
I 2
# zero offsets, back-to-back with no stall, bank v*5+c returns element c*3+v
R 0 01 00 03 06 09 0c 01 04 07 0a 0d 02 05 08 0b 0e
R 5 02 28 2b 2e 31 34 29 2c 2f 32 35 2a 2d 30 33 36
R 30 03 f0 f3 f6 f9 fc f1 f4 f7 fa fd f2 f5 f8 fb fe
R 17 04 88 8b 8e 91 94 89 8c 8f 92 95 8a 8d 90 93 96
R 1 05 08 0b 0e 11 14 09 0c 0f 12 15 0a 0d 10 13 16
I 2
# same rows again under random back-pressure
M 1
R 0 11 00 03 06 09 0c 01 04 07 0a 0d 02 05 08 0b 0e
R 5 12 28 2b 2e 31 34 29 2c 2f 32 35 2a 2d 30 33 36
R 30 13 f0 f3 f6 f9 fc f1 f4 f7 fa fd f2 f5 f8 fb fe
R 17 14 88 8b 8e 91 94 89 8c 8f 92 95 8a 8d 90 93 96
R 1 15 08 0b 0e 11 14 09 0c 0f 12 15 0a 0d 10 13 16
# offset of bank b is b, rows 20 and 30 wrap past the end
O 0 1 2 3 4 5 6 7 8 9 10 11 12 13 14
R 20 21 a0 ab b6 c1 cc c9 d4 df ea f5 f2 05 10 1b 26
R 30 22 f0 03 0e 19 24 21 2c 37 42 4d 4a 55 60 6b 76
R 3 23 18 23 2e 39 44 41 4c 57 62 6d 6a 75 80 8b 96
# largest offset, every bank wraps to the row before the base
O 30 30 30 30 30 30 30 30 30 30 30 30 30 30 30
R 0 31 f0 f3 f6 f9 fc f1 f4 f7 fa fd f2 f5 f8 fb fe
R 10 32 48 4b 4e 51 54 49 4c 4f 52 55 4a 4d 50 53 56
# rewrite row 7, then read it two cycles after the write
O 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
M 0
W 7 a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab ac ad ae
I 1
R 7 41 a0 a3 a6 a9 ac a1 a4 a7 aa ad a2 a5 a8 ab ae
I 3
